// File: sim.f
+incdir+logic
logic/axi_lite_pkg.sv
logic/cluster_ctrl_pkg.sv
logic/axi_lite_regs.sv
logic/ctrl_registers.sv
logic/core_run_tracker.sv
logic/cluster_ctrl_top.sv
test/tb_clk_gen.sv
test/tb_cluster_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cluster control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_cluster_ctrl
output=$(./obj_dir/Vtb_cluster_ctrl)
echo "$output"
if echo "$output" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

// File: test/tb_cluster_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cluster control testbench
// AXI4-Lite master tasks, cycle model and per-cycle output monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "cluster_defines.svh"

module tb_cluster_ctrl;

  localparam int NC = `CLUSTER_NUM_CORES;
  localparam int TO = 50;

  logic                        clk_i;
  logic                        rst_i;
  axi_lite_pkg::req_t          axi_req;
  axi_lite_pkg::resp_t         axi_resp;
  logic [NC-1:0]               core_done;
  cluster_ctrl_pkg::ctrl_out_t ctrl;
  logic [NC-1:0]               running;

  // model state, written only on posedge
  logic [31:0]   m_regs [6];
  logic [NC-1:0] m_running;
  logic [NC-1:0] m_wake;
  logic          m_eoc_valid;
  logic          m_bvalid;
  logic          m_rvalid;
  logic [1:0]    m_bresp;
  logic [1:0]    m_rresp;
  logic [31:0]   m_rdata;
  logic [31:0]   lfsr;
  logic [NC-1:0] seen_wake;
  int            wr_hs_cnt;
  int            rd_hs_cnt;
  int            eoc_cnt;
  int            checks;
  int            errors;

  tb_clk_gen clk_gen_inst (.clk_o(clk_i), .rst_o(rst_i));

  cluster_ctrl_top cluster_ctrl_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .axi_req_i   (axi_req),
    .axi_resp_o  (axi_resp),
    .core_done_i (core_done),
    .ctrl_o      (ctrl),
    .running_o   (running)
  );

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic logic [31:0] reset_val(int i);
    case (i)
      2:       return `CLUSTER_TCDM_BASE;
      3:       return `CLUSTER_TCDM_BASE + `CLUSTER_TCDM_SIZE;
      4:       return 32'(NC);
      default: return '0;
    endcase
  endfunction

  // index below core count, all ones, or nothing
  function automatic logic [NC-1:0] wake_decode(logic [31:0] v);
    if (v < NC) return NC'(1) << v;
    if (v == '1) return '1;
    return '0;
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] d, logic [3:0] s);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) old[8*i +: 8] = d[8*i +: 8];
    end
    return old;
  endfunction

  task automatic check_eq(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout while waiting for %s, the DUT never answered", what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic test_done(string name, int err_before);
    $display("%-24s %s", name, (errors == err_before) ? "passed" : "failed");
  endtask

  // cycle model, inputs are stable at the rising edge
  always @(posedge clk_i) begin : model
    logic          wr_hs;
    logic          rd_hs;
    logic [31:0]   wa;
    logic [NC-1:0] nxt_wake;
    logic          nxt_eoc;
    if (rst_i) begin
      for (int i = 0; i < 6; i++) m_regs[i] = reset_val(i);
      m_running   = '0;
      m_wake      = '0;
      m_eoc_valid = 1'b0;
      m_bvalid    = 1'b0;
      m_rvalid    = 1'b0;
    end else begin
      wr_hs    = axi_req.aw_valid && axi_req.w_valid && !m_bvalid;
      rd_hs    = axi_req.ar_valid && !m_rvalid;
      nxt_eoc  = 1'b0;
      nxt_wake = '0;
      // ready outputs still show the state from before this edge
      check_eq(32'(axi_resp.aw_ready), 32'(wr_hs), "awready");
      check_eq(32'(axi_resp.w_ready), 32'(wr_hs), "wready");
      check_eq(32'(axi_resp.ar_ready), 32'(!m_rvalid), "arready");
      // handshakes as the DUT takes them, followed by the bus tasks
      if (axi_req.aw_valid && axi_resp.aw_ready) wr_hs_cnt++;
      if (axi_req.ar_valid && axi_resp.ar_ready) rd_hs_cnt++;
      // read sees the contents before this edge
      if (rd_hs) begin
        m_rvalid = 1'b1;
        m_rresp  = (axi_req.ar.addr < 24) ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        m_rdata  = (axi_req.ar.addr < 24) ? m_regs[axi_req.ar.addr[4:2]] : '0;
      end else if (axi_req.r_ready) begin
        m_rvalid = 1'b0;
      end
      if (wr_hs) begin
        m_bvalid = 1'b1;
        wa       = axi_req.aw.addr;
        if (wa >= 24 || (wa[4:2] >= 2 && axi_req.w.strb != 0)) begin
          m_bresp = axi_lite_pkg::RESP_SLVERR;
        end else begin
          m_bresp = axi_lite_pkg::RESP_OKAY;
          if (axi_req.w.strb != 0) begin
            m_regs[wa[4:2]] = merge(m_regs[wa[4:2]], axi_req.w.data, axi_req.w.strb);
            nxt_eoc = (wa[4:2] == 0);
            if (wa[4:2] == 1) nxt_wake = wake_decode(m_regs[1]);
          end
        end
      end else if (axi_req.b_ready) begin
        m_bvalid = 1'b0;
      end
      // status word trails the tracker by one cycle, wake beats done
      m_regs[5]   = 32'(m_running);
      m_running   = (m_running & ~core_done) | m_wake;
      m_wake      = nxt_wake;
      m_eoc_valid = nxt_eoc;
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (!rst_i) begin
      check_eq(ctrl.eoc, m_regs[0], "eoc");
      check_eq(32'(ctrl.eoc_valid), 32'(m_eoc_valid), "eoc_valid");
      check_eq(32'(ctrl.wake), 32'(m_wake), "wake");
      check_eq(32'(running), 32'(m_running), "running");
      check_eq(32'(axi_resp.b_valid), 32'(m_bvalid), "bvalid");
      check_eq(32'(axi_resp.r_valid), 32'(m_rvalid), "rvalid");
      if (m_bvalid) check_eq(32'(axi_resp.b.resp), 32'(m_bresp), "bresp");
      if (m_rvalid) begin
        check_eq(axi_resp.r.data, m_rdata, "rdata");
        check_eq(32'(axi_resp.r.resp), 32'(m_rresp), "rresp");
      end
      if (ctrl.eoc_valid) eoc_cnt++;
      seen_wake = seen_wake | ctrl.wake;
    end
  end

  // done_hs goes out in the cycle of the wake pulse
  task automatic axi_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                           logic [NC-1:0] done_hs, bit stall, output logic [1:0] resp);
    int          t;
    int          base;
    logic [31:0] n;
    @(negedge clk_i);
    axi_req.aw_valid = 1'b1;
    axi_req.aw.addr  = addr;
    axi_req.w_valid  = 1'b1;
    axi_req.w.data   = data;
    axi_req.w.strb   = strb;
    base = wr_hs_cnt;
    t    = 0;
    while (wr_hs_cnt == base) begin
      @(negedge clk_i);
      t++;
      if (t > TO) timeout_fail("the write handshake");
    end
    axi_req.aw_valid = 1'b0;
    axi_req.w_valid  = 1'b0;
    core_done        = done_hs;
    @(negedge clk_i);
    core_done = '0;
    t = 0;
    while (!axi_resp.b_valid) begin
      @(negedge clk_i);
      t++;
      if (t > TO) timeout_fail("the write response");
    end
    resp = axi_resp.b.resp;
    n    = stall ? rand_bits(2) : 0;
    repeat (n) @(negedge clk_i);
    axi_req.b_ready = 1'b1;
    @(negedge clk_i);
    axi_req.b_ready = 1'b0;
  endtask

  task automatic axi_read(logic [31:0] addr, bit stall, output logic [31:0] data,
                          output logic [1:0] resp);
    int          t;
    int          base;
    logic [31:0] n;
    @(negedge clk_i);
    axi_req.ar_valid = 1'b1;
    axi_req.ar.addr  = addr;
    base = rd_hs_cnt;
    t    = 0;
    while (rd_hs_cnt == base) begin
      @(negedge clk_i);
      t++;
      if (t > TO) timeout_fail("the read handshake");
    end
    axi_req.ar_valid = 1'b0;
    t = 0;
    while (!axi_resp.r_valid) begin
      @(negedge clk_i);
      t++;
      if (t > TO) timeout_fail("the read data");
    end
    data = axi_resp.r.data;
    resp = axi_resp.r.resp;
    n    = stall ? rand_bits(2) : 0;
    repeat (n) @(negedge clk_i);
    axi_req.r_ready = 1'b1;
    @(negedge clk_i);
    axi_req.r_ready = 1'b0;
  endtask

  // only cores that are running may report done
  task automatic pulse_done(logic [NC-1:0] mask);
    @(negedge clk_i);
    core_done = mask & m_running;
    @(negedge clk_i);
    core_done = '0;
  endtask

  task automatic wait_running(logic [NC-1:0] mask);
    int t;
    t = 0;
    while ((running & mask) != mask) begin
      @(negedge clk_i);
      t++;
      if (t > TO) timeout_fail("cores to start running");
    end
  endtask

  initial begin : main
    int            t;
    int            e;
    logic [31:0]   d;
    logic [31:0]   x;
    logic [31:0]   old;
    logic [31:0]   vals [3];
    logic [1:0]    r;
    logic [3:0]    s;
    logic [NC-1:0] c;
    lfsr      = 32'hdff26918;
    axi_req   = '0;
    core_done = '0;
    seen_wake = '0;
    wr_hs_cnt = 0;
    rd_hs_cnt = 0;
    eoc_cnt   = 0;
    checks    = 0;
    errors    = 0;
    t = 0;
    while (rst_i !== 1'b0) begin
      @(negedge clk_i);
      t++;
      if (t > TO) timeout_fail("reset release");
    end

    e = errors;
    for (int i = 0; i < 6; i++) begin
      axi_read(32'(i * 4), 1'b0, d, r);
      check_eq(d, reset_val(i), "reset value");
      check_eq(32'(r), 32'(axi_lite_pkg::RESP_OKAY), "reset read resp");
    end
    test_done("reset values", e);

    e   = errors;
    old = m_regs[0];
    d   = rand_bits(32);
    x   = rand_bits(4);
    s   = (x[3:0] == 0) ? 4'hf : x[3:0];
    t   = eoc_cnt;
    axi_write(cluster_ctrl_pkg::EOC_OFFS, d, s, '0, 1'b0, r);
    check_eq(32'(eoc_cnt - t), 1, "eoc pulse count");
    axi_read(cluster_ctrl_pkg::EOC_OFFS, 1'b0, x, r);
    check_eq(x, merge(old, d, s), "eoc read-back");
    test_done("eoc write", e);

    // in range, all ones, then an index past the last core
    e       = errors;
    vals[0] = rand_bits(3);
    vals[1] = '1;
    vals[2] = 32'(NC) + rand_bits(4);
    for (int i = 0; i < 3; i++) begin
      seen_wake = '0;
      axi_write(cluster_ctrl_pkg::WAKE_OFFS, vals[i], 4'hf, '0, 1'b0, r);
      check_eq(32'(seen_wake), 32'(wake_decode(vals[i])), "wake vector");
      wait_running(wake_decode(vals[i]));
      axi_read(cluster_ctrl_pkg::RUNNING_OFFS, 1'b0, d, r);
    end
    test_done("wake decode", e);

    // at least one core reports done
    e = errors;
    x = rand_bits(NC);
    c = (x[NC-1:0] == '0) ? '1 : x[NC-1:0];
    pulse_done(c);
    check_eq(32'(running & c), 0, "done clears running");
    x = rand_bits(3);
    c = NC'(1) << x[2:0];
    axi_write(cluster_ctrl_pkg::WAKE_OFFS, x, 4'hf, '0, 1'b0, r);
    wait_running(c);
    axi_write(cluster_ctrl_pkg::WAKE_OFFS, x, 4'hf, c, 1'b0, r);
    @(negedge clk_i);
    check_eq(32'(running & c), 32'(c), "wake beats done");
    test_done("done bits", e);

    e = errors;
    axi_write(cluster_ctrl_pkg::TCDM_START_OFFS, rand_bits(32), 4'hf, '0, 1'b0, r);
    check_eq(32'(r), 32'(axi_lite_pkg::RESP_SLVERR), "read-only write resp");
    axi_write(32'h18 + 4 * rand_bits(6), rand_bits(32), 4'hf, '0, 1'b0, r);
    check_eq(32'(r), 32'(axi_lite_pkg::RESP_SLVERR), "out of range write resp");
    axi_read(32'h18 + 4 * rand_bits(6), 1'b0, d, r);
    check_eq(d, 0, "out of range read data");
    check_eq(32'(r), 32'(axi_lite_pkg::RESP_SLVERR), "out of range read resp");
    axi_read(cluster_ctrl_pkg::TCDM_START_OFFS, 1'b0, d, r);
    check_eq(d, `CLUSTER_TCDM_BASE, "tcdm start kept");
    test_done("error responses", e);

    // the monitor compares every cycle against the model
    e = errors;
    for (int i = 0; i < 300; i++) begin
      x = rand_bits(2);
      case (x[1:0])
        2'd0: begin
          d = 4 * rand_bits(3);
          old = rand_bits(32);
          if (d == cluster_ctrl_pkg::WAKE_OFFS) begin
            old = rand_bits(1) != 0 ? '1 : rand_bits(4);
          end
          x = rand_bits(4);
          axi_write(d, old, x[3:0], '0, 1'b1, r);
        end
        2'd1: axi_read(4 * rand_bits(3), 1'b1, d, r);
        2'd2: begin
          x = rand_bits(NC);
          pulse_done(x[NC-1:0]);
        end
        default: repeat (rand_bits(2) + 1) @(negedge clk_i);
      endcase
    end
    test_done("random mix", e);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// 20 ns clock, reset held high for the first 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release on a falling edge so the first active posedge is clean
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: logic/cluster_ctrl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cluster control top
// register block on AXI4-Lite plus the per-core run tracker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "cluster_defines.svh"

module cluster_ctrl_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  axi_lite_pkg::req_t            axi_req_i,
  output axi_lite_pkg::resp_t           axi_resp_o,
  input  logic [`CLUSTER_NUM_CORES-1:0] core_done_i,
  output cluster_ctrl_pkg::ctrl_out_t   ctrl_o,
  output logic [`CLUSTER_NUM_CORES-1:0] running_o
);

  // register map, running mask comes back as status
  ctrl_registers ctrl_registers_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .axi_req_i  (axi_req_i),
    .axi_resp_o (axi_resp_o),
    .running_i  (running_o),
    .ctrl_o     (ctrl_o)
  );

  // wake pulses from the register block drive the tracker
  core_run_tracker core_run_tracker_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wake_i      (ctrl_o.wake),
    .core_done_i (core_done_i),
    .running_o   (running_o)
  );

endmodule

// File: logic/core_run_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core run tracker
// one running bit per core, set by wake and cleared by done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "cluster_defines.svh"

module core_run_tracker (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // one-cycle wake pulse per core
  input  logic [`CLUSTER_NUM_CORES-1:0] wake_i,
  // core reports end of its work
  input  logic [`CLUSTER_NUM_CORES-1:0] core_done_i,
  output logic [`CLUSTER_NUM_CORES-1:0] running_o
);

  logic [`CLUSTER_NUM_CORES-1:0] running_q;
  logic [`CLUSTER_NUM_CORES-1:0] running_d;

  // clear on done first, then set on wake
  // so a wake in the same cycle keeps the core running
  always_comb begin
    running_d = running_q & ~core_done_i;
    running_d = running_d | wake_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  assign running_o = running_q;

  // cores only finish work they were woken for
  done_running_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (core_done_i & ~running_q) == '0);

endmodule

// File: logic/ctrl_registers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cluster control register map
// eoc word with valid pulse, wake decode and status registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "cluster_defines.svh"

module ctrl_registers (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  axi_lite_pkg::req_t             axi_req_i,
  output axi_lite_pkg::resp_t            axi_resp_o,
  input  logic [`CLUSTER_NUM_CORES-1:0]  running_i,
  output cluster_ctrl_pkg::ctrl_out_t    ctrl_o
);

  localparam int unsigned DW     = `CLUSTER_DATA_WIDTH;
  localparam int unsigned AW     = `CLUSTER_ADDR_WIDTH;
  localparam int unsigned NC     = `CLUSTER_NUM_CORES;
  localparam int unsigned STRB_W = `CLUSTER_STRB_WIDTH;
  localparam int unsigned NBYTES = `CLUSTER_REG_BYTES;

  logic [NBYTES-1:0]   wr_active;
  logic [NBYTES-1:0]   wr_active_q;
  logic [NBYTES*8-1:0] reg_d;
  logic [NBYTES-1:0]   reg_load;
  logic [NBYTES*8-1:0] reg_q;
  logic [DW-1:0]       wake_val;

  axi_lite_regs axi_lite_regs_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .axi_req_i   (axi_req_i),
    .axi_resp_o  (axi_resp_o),
    .wr_active_o (wr_active),
    .reg_d_i     (reg_d),
    .reg_load_i  (reg_load),
    .reg_q_o     (reg_q)
  );

  // load port: reset values while in reset, running mask afterwards
  // status words other than running keep their reset value
  always_comb begin
    reg_d    = '0;
    reg_load = '0;
    if (rst_i) begin
      reg_load = '1;
      reg_d[8*cluster_ctrl_pkg::TCDM_START_OFFS +: DW] = `CLUSTER_TCDM_BASE;
      reg_d[8*cluster_ctrl_pkg::TCDM_END_OFFS +: DW]   =
        `CLUSTER_TCDM_BASE + `CLUSTER_TCDM_SIZE;
      reg_d[8*cluster_ctrl_pkg::NUM_CORES_OFFS +: DW]  = DW'(NC);
    end else begin
      reg_load[cluster_ctrl_pkg::RUNNING_OFFS +: STRB_W] = '1;
      reg_d[8*cluster_ctrl_pkg::RUNNING_OFFS +: DW]      = DW'(running_i);
    end
  end

  // one cycle delay so the pulses line up with the updated register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_active_q <= '0;
    end else begin
      wr_active_q <= wr_active;
    end
  end

  assign ctrl_o.eoc       = reg_q[8*cluster_ctrl_pkg::EOC_OFFS +: DW];
  assign ctrl_o.eoc_valid = |wr_active_q[cluster_ctrl_pkg::EOC_OFFS +: STRB_W];

  assign wake_val = reg_q[8*cluster_ctrl_pkg::WAKE_OFFS +: DW];

  // index below core count wakes one core, all ones wakes all
  always_comb begin
    ctrl_o.wake = '0;
    if (|wr_active_q[cluster_ctrl_pkg::WAKE_OFFS +: STRB_W]) begin
      for (int c = 0; c < NC; c++) begin
        ctrl_o.wake[c] = (wake_val == DW'(c));
      end
      if (wake_val == {DW{1'b1}}) begin
        ctrl_o.wake = '1;
      end
    end
  end

  // a wake pulse needs a strobed bus write to the wake word at the previous edge
  wake_src_a : assert property (@(posedge clk_i) disable iff (rst_i)
    |ctrl_o.wake |-> $past(axi_req_i.aw_valid && axi_resp_o.aw_ready &&
      (|axi_req_i.w.strb) &&
      axi_req_i.aw.addr[AW-1:2] == (AW-2)'(cluster_ctrl_pkg::WAKE_OFFS / 4)));

endmodule

// File: logic/axi_lite_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite byte register file
// strobed writes with a read-only mask, per-byte write flags and a
// hardware load port for status bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "cluster_defines.svh"

module axi_lite_regs (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  axi_lite_pkg::req_t                      axi_req_i,
  output axi_lite_pkg::resp_t                     axi_resp_o,
  output logic [`CLUSTER_REG_BYTES-1:0]           wr_active_o,
  input  logic [`CLUSTER_REG_BYTES*8-1:0]         reg_d_i,
  input  logic [`CLUSTER_REG_BYTES-1:0]           reg_load_i,
  output logic [`CLUSTER_REG_BYTES*8-1:0]         reg_q_o
);

  localparam int unsigned REG_BYTES = `CLUSTER_REG_BYTES;
  localparam int unsigned STRB_W    = `CLUSTER_STRB_WIDTH;
  localparam int unsigned AW        = `CLUSTER_ADDR_WIDTH;
  localparam int unsigned DW        = `CLUSTER_DATA_WIDTH;

  // register storage, byte granular
  logic [REG_BYTES-1:0][7:0] reg_q;

  // write side
  logic                 wr_hs;
  logic                 wr_in_range;
  logic                 wr_err;
  logic [REG_BYTES-1:0] wr_sel;
  logic                 bvalid_q;
  axi_lite_pkg::b_chan_t b_q;

  // read side
  logic                 rd_hs;
  logic                 rd_in_range;
  logic [DW-1:0]        rd_data;
  logic                 rvalid_q;
  axi_lite_pkg::r_chan_t r_q;

  // aw and w are taken together, only with no response waiting
  assign wr_hs = axi_req_i.aw_valid && axi_req_i.w_valid && !bvalid_q;
  // one read in flight at most
  assign rd_hs = axi_req_i.ar_valid && !rvalid_q;

  // write decode
  always_comb begin
    wr_in_range = axi_req_i.aw.addr < AW'(REG_BYTES);
    // bytes of the addressed word that carry a strobe
    for (int i = 0; i < REG_BYTES; i++) begin
      wr_sel[i] = (axi_req_i.aw.addr[AW-1:2] == (AW-2)'(i / STRB_W)) &&
                  axi_req_i.w.strb[i % STRB_W];
    end
    // any strobed read-only byte rejects the whole write
    wr_err = !wr_in_range || (|(wr_sel & cluster_ctrl_pkg::REG_READ_ONLY));
    wr_active_o = (wr_hs && !wr_err) ? wr_sel : '0;
  end

  // read mux, zero outside the map
  always_comb begin
    rd_in_range = axi_req_i.ar.addr < AW'(REG_BYTES);
    rd_data     = '0;
    for (int w = 0; w < REG_BYTES / STRB_W; w++) begin
      if (axi_req_i.ar.addr[AW-1:2] == (AW-2)'(w)) begin
        rd_data = reg_q[w*STRB_W +: STRB_W];
      end
    end
  end

  // response handshake state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axi_req_i.b_ready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axi_req_i.r_ready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // response payloads, captured at the handshake
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      b_q.resp <= wr_err ? axi_lite_pkg::RESP_SLVERR : axi_lite_pkg::RESP_OKAY;
    end
    if (rd_hs) begin
      r_q.data <= rd_data;
      r_q.resp <= rd_in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
    end
  end

  // byte update, bus write first, then hardware load
  // wr_active never covers read-only bytes so the load owns those
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < REG_BYTES; i++) begin
      if (wr_active_o[i]) begin
        reg_q[i] <= axi_req_i.w.data[8*(i % STRB_W) +: 8];
      end else if (reg_load_i[i]) begin
        reg_q[i] <= reg_d_i[8*i +: 8];
      end
    end
  end

  assign reg_q_o = reg_q;

  assign axi_resp_o.aw_ready = wr_hs;
  assign axi_resp_o.w_ready  = wr_hs;
  assign axi_resp_o.b_valid  = bvalid_q;
  assign axi_resp_o.b        = b_q;
  assign axi_resp_o.ar_ready = !rvalid_q;
  assign axi_resp_o.r_valid  = rvalid_q;
  assign axi_resp_o.r        = r_q;

  // B and its payload must stay put until the master takes it
  b_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    axi_resp_o.b_valid && !axi_req_i.b_ready |=>
      axi_resp_o.b_valid && $stable(axi_resp_o.b));

  // same for R
  r_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    axi_resp_o.r_valid && !axi_req_i.r_ready |=>
      axi_resp_o.r_valid && $stable(axi_resp_o.r));

endmodule

// File: logic/cluster_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cluster control register map
// byte offsets, read-only byte mask and the control output bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cluster_defines.svh"

package cluster_ctrl_pkg;

  // byte offsets of the six registers
  // eoc and wake are writable, the rest are status
  localparam int unsigned EOC_OFFS        = 'h00;
  localparam int unsigned WAKE_OFFS       = 'h04;
  localparam int unsigned TCDM_START_OFFS = 'h08;
  localparam int unsigned TCDM_END_OFFS   = 'h0C;
  localparam int unsigned NUM_CORES_OFFS  = 'h10;
  localparam int unsigned RUNNING_OFFS    = 'h14;

  // one bit per register byte, set means the bus cannot write it
  // bytes 0..7 (eoc, wake) are writable, bytes 8..23 are not
  localparam logic [`CLUSTER_REG_BYTES-1:0] REG_READ_ONLY = {
    {(4 * `CLUSTER_STRB_WIDTH){1'b1}},
    {(2 * `CLUSTER_STRB_WIDTH){1'b0}}
  };

  // signals that leave the cluster towards the host side
  typedef struct packed {
    // end-of-computation word as last written
    logic [`CLUSTER_DATA_WIDTH-1:0] eoc;
    // one-cycle pulse after an eoc write
    logic                           eoc_valid;
    // one-cycle per-core wake pulse
    logic [`CLUSTER_NUM_CORES-1:0]  wake;
  } ctrl_out_t;

endpackage

// File: logic/axi_lite_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite channel types
// payload structs for the five channels, request/response bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cluster_defines.svh"

package axi_lite_pkg;

  // response codes, only the two used by the register file
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // write address
  typedef struct packed {
    logic [`CLUSTER_ADDR_WIDTH-1:0] addr;
    logic [2:0]                     prot;
  } aw_chan_t;

  // write data, one word with byte strobes
  typedef struct packed {
    logic [`CLUSTER_DATA_WIDTH-1:0] data;
    logic [`CLUSTER_STRB_WIDTH-1:0] strb;
  } w_chan_t;

  // write response
  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  // read address
  typedef struct packed {
    logic [`CLUSTER_ADDR_WIDTH-1:0] addr;
    logic [2:0]                     prot;
  } ar_chan_t;

  // read data
  typedef struct packed {
    logic [`CLUSTER_DATA_WIDTH-1:0] data;
    logic [1:0]                     resp;
  } r_chan_t;

  // master side: valids, b/r readies and request payloads
  typedef struct packed {
    logic     aw_valid;
    aw_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     b_ready;
    logic     ar_valid;
    ar_chan_t ar;
    logic     r_ready;
  } req_t;

  // slave side: readies, b/r valids and response payloads
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    logic     b_valid;
    b_chan_t  b;
    logic     ar_ready;
    logic     r_valid;
    r_chan_t  r;
  } resp_t;

endpackage

// File: logic/cluster_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cluster control block sizes
// bus widths, core count, register count and the TCDM window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CLUSTER_DEFINES_SVH
`define CLUSTER_DEFINES_SVH

// register and AXI data width in bits
`define CLUSTER_DATA_WIDTH 32
// AXI address width in bits
`define CLUSTER_ADDR_WIDTH 32
// one strobe bit per data byte
`define CLUSTER_STRB_WIDTH (`CLUSTER_DATA_WIDTH / 8)

// cores in the cluster, width of wake and running vectors
`define CLUSTER_NUM_CORES 8
// one word per register
`define CLUSTER_NUM_REGS 6
// total bytes in the register file
`define CLUSTER_REG_BYTES (`CLUSTER_NUM_REGS * `CLUSTER_STRB_WIDTH)

// shared memory window reported to software
`define CLUSTER_TCDM_BASE 32'h1000_0000
`define CLUSTER_TCDM_SIZE 32'h0010_0000

`endif
